// ==== Makefile ====
VERILATOR   ?= verilator
TOP         := conflict_checker_tb
RTL_TOP     := conflict_checker
FILELIST    := conflict_checker.f
BUILD_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS  := --lint-only --timing --assert
OBJ_DIR     := obj_dir
LOG         := sim.log
PASS_MSG    := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== conflict_checker.f ====
verilog/txn_pkg.sv
verilog/perf_pkg.sv
verilog/dep_conflict_check.sv
verilog/batch_dep_tracker.sv
verilog/conflict_ctrl.sv
verilog/perf_counters.sv
verilog/conflict_checker.sv
sim/conflict_checker_tb.sv

// ==== sim/conflict_checker_tb.sv ====
`timescale 1ns/1ps

module conflict_checker_tb import txn_pkg::*, perf_pkg::*; ();

    localparam int NUM_BATCHES     = 4;
    localparam int TXNS_PER_BATCH  = 15;
    localparam int NUM_TXNS        = NUM_BATCHES * TXNS_PER_BATCH;
    localparam int RESET_CYCLES    = 10;
    localparam int WATCHDOG_CYCLES = NUM_TXNS * 40 + RESET_CYCLES;

    logic             clk;
    logic             rst_n;
    logic             batch_completed;
    logic             in_valid;
    logic             in_ready;
    logic [ID_W-1:0]  in_owner_id;
    logic [DEP_W-1:0] in_read_deps;
    logic [DEP_W-1:0] in_write_deps;
    logic             out_valid;
    logic             out_ready;
    logic [ID_W-1:0]  out_owner_id;
    logic [DEP_W-1:0] out_read_deps;
    logic [DEP_W-1:0] out_write_deps;
    logic [CNT_W-1:0] raw_conflicts;
    logic [CNT_W-1:0] waw_conflicts;
    logic [CNT_W-1:0] war_conflicts;
    logic [CNT_W-1:0] filter_hits;
    logic [CNT_W-1:0] transactions_processed;

    // Reference state of the running batch and expected counters
    logic [DEP_W-1:0] model_reads;
    logic [DEP_W-1:0] model_writes;
    logic [CNT_W-1:0] exp_raw;
    logic [CNT_W-1:0] exp_waw;
    logic [CNT_W-1:0] exp_war;
    logic [CNT_W-1:0] exp_filter;
    logic [CNT_W-1:0] exp_processed;

    // Transactions expected on the output in order of arrival
    logic [ID_W-1:0]  exp_id_q[$];
    logic [DEP_W-1:0] exp_rd_q[$];
    logic [DEP_W-1:0] exp_wr_q[$];

    // Snapshot of the output while the sink stalls
    logic             stall_seen;
    logic [ID_W-1:0]  stall_id;
    logic [DEP_W-1:0] stall_rd;
    logic [DEP_W-1:0] stall_wr;

    int errors;
    int n_forwarded;
    int n_rejected;

    conflict_checker conflict_checker_i (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .batch_completed        (batch_completed),
        .in_valid               (in_valid),
        .in_ready               (in_ready),
        .in_owner_id            (in_owner_id),
        .in_read_deps           (in_read_deps),
        .in_write_deps          (in_write_deps),
        .out_valid              (out_valid),
        .out_ready              (out_ready),
        .out_owner_id           (out_owner_id),
        .out_read_deps          (out_read_deps),
        .out_write_deps         (out_write_deps),
        .raw_conflicts          (raw_conflicts),
        .waw_conflicts          (waw_conflicts),
        .war_conflicts          (war_conflicts),
        .filter_hits            (filter_hits),
        .transactions_processed (transactions_processed)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected flags {raw, waw, war} of a transaction against the batch sets
    function automatic logic [2:0] ref_conflicts(input logic [DEP_W-1:0] rd,
                                                 input logic [DEP_W-1:0] wr,
                                                 input logic [DEP_W-1:0] set_r,
                                                 input logic [DEP_W-1:0] set_w);
        logic [2:0] f;
        f[2] = |(rd & set_w);
        f[1] = |(wr & set_w);
        f[0] = |(wr & set_r);
        return f;
    endfunction

    // Sparse vector with few positions per slice so conflicts are common
    function automatic logic [DEP_W-1:0] make_deps(input int count);
        logic [DEP_W-1:0] v;
        int               idx;
        int               k;
        v = '0;
        for (k = 0; k < count; k++) begin
            idx = $urandom_range(0, NUM_CHUNKS - 1) * CHUNK_W + $urandom_range(0, 7);
            v = v | ({{(DEP_W - 1){1'b0}}, 1'b1} << idx);
        end
        return v;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic check_counters();
        if (raw_conflicts != exp_raw)
            report_mismatch($sformatf("raw_conflicts %0d, expected %0d", raw_conflicts, exp_raw));
        if (waw_conflicts != exp_waw)
            report_mismatch($sformatf("waw_conflicts %0d, expected %0d", waw_conflicts, exp_waw));
        if (war_conflicts != exp_war)
            report_mismatch($sformatf("war_conflicts %0d, expected %0d", war_conflicts, exp_war));
        if (filter_hits != exp_filter)
            report_mismatch($sformatf("filter_hits %0d, expected %0d", filter_hits, exp_filter));
        if (transactions_processed != exp_processed)
            report_mismatch($sformatf("transactions_processed %0d, expected %0d",
                                      transactions_processed, exp_processed));
    endtask

    task automatic send_txn(input logic [ID_W-1:0] id, input logic [DEP_W-1:0] rd,
                            input logic [DEP_W-1:0] wr);
        @(posedge clk);
        in_valid      <= 1'b1;
        in_owner_id   <= id;
        in_read_deps  <= rd;
        in_write_deps <= wr;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        // This edge takes the transaction
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic end_batch();
        @(posedge clk);
        batch_completed <= 1'b1;
        @(posedge clk);
        batch_completed <= 1'b0;
        model_reads   = '0;
        model_writes  = '0;
        exp_processed = '0;
        @(negedge clk);
        check_counters();
    endtask

    // Sink drops ready for a few cycles at a time
    initial begin : ready_driver
        int stall;
        stall = 0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            if (stall > 0) begin
                out_ready <= 1'b0;
                stall = stall - 1;
            end else if ($urandom_range(0, 3) == 0) begin
                out_ready <= 1'b0;
                stall = $urandom_range(1, 3);
            end else begin
                out_ready <= 1'b1;
            end
        end
    end

    // Output compare sampled mid-cycle where everything has settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid && in_ready)
                report_mismatch("input ready while a transaction waits on the output");
            if (stall_seen) begin
                if (!out_valid || out_owner_id != stall_id || out_read_deps != stall_rd ||
                    out_write_deps != stall_wr)
                    report_mismatch("output changed while out_ready was low");
            end
            if (out_valid && out_ready) begin
                stall_seen = 1'b0;
                if (exp_id_q.size() == 0) begin
                    report_mismatch($sformatf("unexpected output id %h", out_owner_id));
                end else begin
                    if (out_owner_id != exp_id_q[0])
                        report_mismatch($sformatf("output id %h, expected %h",
                                                  out_owner_id, exp_id_q[0]));
                    if (out_read_deps != exp_rd_q[0])
                        report_mismatch("output read deps differ from the input");
                    if (out_write_deps != exp_wr_q[0])
                        report_mismatch("output write deps differ from the input");
                    void'(exp_id_q.pop_front());
                    void'(exp_rd_q.pop_front());
                    void'(exp_wr_q.pop_front());
                end
            end else if (out_valid) begin
                stall_seen = 1'b1;
                stall_id   = out_owner_id;
                stall_rd   = out_read_deps;
                stall_wr   = out_write_deps;
            end else begin
                stall_seen = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        logic [ID_W-1:0]  id;
        logic [DEP_W-1:0] rd;
        logic [DEP_W-1:0] wr;
        logic [DEP_W-1:0] last_rd;
        logic [DEP_W-1:0] last_wr;
        logic [2:0]       flags;
        void'($urandom(97947));
        rst_n           = 1'b0;
        batch_completed = 1'b0;
        in_valid        = 1'b0;
        in_owner_id     = '0;
        in_read_deps    = '0;
        in_write_deps   = '0;
        out_ready       = 1'b0;
        model_reads     = '0;
        model_writes    = '0;
        exp_raw         = '0;
        exp_waw         = '0;
        exp_war         = '0;
        exp_filter      = '0;
        exp_processed   = '0;
        stall_seen      = 1'b0;
        last_rd         = '0;
        last_wr         = '0;
        errors          = 0;
        n_forwarded     = 0;
        n_rejected      = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (!in_ready)
            report_mismatch("in_ready low after reset");
        if (out_valid)
            report_mismatch("out_valid high after reset");
        check_counters();

        for (int b = 0; b < NUM_BATCHES; b++) begin
            for (int t = 0; t < TXNS_PER_BATCH; t++) begin
                id = {$urandom, $urandom};
                if (b > 0 && t == 0) begin
                    // Repeat deps that were committed in the previous batch
                    rd = last_rd;
                    wr = last_wr;
                end else begin
                    rd = make_deps($urandom_range(1, 3));
                    wr = make_deps($urandom_range(1, 2));
                end
                flags = ref_conflicts(rd, wr, model_reads, model_writes);
                if (flags == 3'b000) begin
                    exp_id_q.push_back(id);
                    exp_rd_q.push_back(rd);
                    exp_wr_q.push_back(wr);
                end
                send_txn(id, rd, wr);
                wait_idle();
                if (flags == 3'b000) begin
                    model_reads  = model_reads | rd;
                    model_writes = model_writes | wr;
                    last_rd      = rd;
                    last_wr      = wr;
                    n_forwarded++;
                end else begin
                    exp_filter = exp_filter + 1;
                    if (flags[2])
                        exp_raw = exp_raw + 1;
                    if (flags[1])
                        exp_waw = exp_waw + 1;
                    if (flags[0])
                        exp_war = exp_war + 1;
                    n_rejected++;
                end
                exp_processed = exp_processed + 1;
                if (exp_id_q.size() != 0)
                    report_mismatch("forwarded transaction missing on the output");
                check_counters();
            end
            end_batch();
        end

        if (n_forwarded == 0 || n_rejected == 0)
            report_problem("Stimulus did not produce both forwarded and dropped transactions");

        $display("Errors: %0d, transactions forwarded: %0d, dropped: %0d",
                 errors, n_forwarded, n_rejected);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/batch_dep_tracker.sv ====
`timescale 1ns/1ps

module batch_dep_tracker import txn_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             batch_completed,
    input  logic             commit,
    input  logic [DEP_W-1:0] read_deps,
    input  logic [DEP_W-1:0] write_deps,
    output logic [DEP_W-1:0] batch_reads,
    output logic [DEP_W-1:0] batch_writes
);

    // Accumulated read and write sets of the running batch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            batch_reads  <= '0;
            batch_writes <= '0;
        end else if (batch_completed) begin
            // New batch starts empty, even if a commit lands in the same cycle
            batch_reads  <= '0;
            batch_writes <= '0;
        end else if (commit) begin
            batch_reads  <= batch_reads | read_deps;
            batch_writes <= batch_writes | write_deps;
        end
    end

    // Sets are empty in the cycle after a batch ends
    a_clear_on_batch_end: assert property (
        @(posedge clk) disable iff (!rst_n)
        batch_completed |=> (batch_reads == '0) && (batch_writes == '0)
    );

endmodule

// ==== verilog/conflict_checker.sv ====
`timescale 1ns/1ps

module conflict_checker import txn_pkg::*, perf_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             batch_completed,

    // Transaction input
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [ID_W-1:0]  in_owner_id,
    input  logic [DEP_W-1:0] in_read_deps,
    input  logic [DEP_W-1:0] in_write_deps,

    // Conflict-free transaction output
    output logic             out_valid,
    input  logic             out_ready,
    output logic [ID_W-1:0]  out_owner_id,
    output logic [DEP_W-1:0] out_read_deps,
    output logic [DEP_W-1:0] out_write_deps,

    // Performance counters
    output logic [CNT_W-1:0] raw_conflicts,
    output logic [CNT_W-1:0] waw_conflicts,
    output logic [CNT_W-1:0] war_conflicts,
    output logic [CNT_W-1:0] filter_hits,
    output logic [CNT_W-1:0] transactions_processed
);

    logic [DEP_W-1:0] held_read_deps;
    logic [DEP_W-1:0] held_write_deps;
    logic [DEP_W-1:0] batch_reads;
    logic [DEP_W-1:0] batch_writes;
    logic             raw;
    logic             waw;
    logic             war;
    logic             commit;
    logic             reject;
    logic             done;

    dep_conflict_check dep_conflict_check_i (
        .read_deps    (held_read_deps),
        .write_deps   (held_write_deps),
        .batch_reads  (batch_reads),
        .batch_writes (batch_writes),
        .raw          (raw),
        .waw          (waw),
        .war          (war)
    );

    batch_dep_tracker batch_dep_tracker_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .batch_completed (batch_completed),
        .commit          (commit),
        .read_deps       (held_read_deps),
        .write_deps      (held_write_deps),
        .batch_reads     (batch_reads),
        .batch_writes    (batch_writes)
    );

    conflict_ctrl conflict_ctrl_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .batch_completed (batch_completed),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_owner_id     (in_owner_id),
        .in_read_deps    (in_read_deps),
        .in_write_deps   (in_write_deps),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_owner_id    (out_owner_id),
        .out_read_deps   (out_read_deps),
        .out_write_deps  (out_write_deps),
        .held_read_deps  (held_read_deps),
        .held_write_deps (held_write_deps),
        .raw             (raw),
        .waw             (waw),
        .war             (war),
        .commit          (commit),
        .reject          (reject),
        .done            (done)
    );

    perf_counters perf_counters_i (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .batch_completed        (batch_completed),
        .reject                 (reject),
        .done                   (done),
        .raw                    (raw),
        .waw                    (waw),
        .war                    (war),
        .raw_conflicts          (raw_conflicts),
        .waw_conflicts          (waw_conflicts),
        .war_conflicts          (war_conflicts),
        .filter_hits            (filter_hits),
        .transactions_processed (transactions_processed)
    );

endmodule

// ==== verilog/conflict_ctrl.sv ====
`timescale 1ns/1ps

module conflict_ctrl import txn_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             batch_completed,

    // Transaction input
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [ID_W-1:0]  in_owner_id,
    input  logic [DEP_W-1:0] in_read_deps,
    input  logic [DEP_W-1:0] in_write_deps,

    // Forwarded transaction output
    output logic             out_valid,
    input  logic             out_ready,
    output logic [ID_W-1:0]  out_owner_id,
    output logic [DEP_W-1:0] out_read_deps,
    output logic [DEP_W-1:0] out_write_deps,

    // Held vectors go to the conflict check and the tracker
    output logic [DEP_W-1:0] held_read_deps,
    output logic [DEP_W-1:0] held_write_deps,
    input  logic             raw,
    input  logic             waw,
    input  logic             war,

    // Event pulses
    output logic             commit,
    output logic             reject,
    output logic             done
);

    typedef enum logic [1:0] {
        IDLE     = 2'b00,
        CHECK    = 2'b01,
        OUTPUT   = 2'b10,
        COMPLETE = 2'b11
    } state_t;

    state_t          state;
    logic [ID_W-1:0] held_owner_id;
    logic            conflict;
    logic            in_fire;
    logic            out_fire;

    assign conflict = raw | waw | war;
    assign in_ready = (state == IDLE);
    assign in_fire  = in_valid & in_ready;
    assign out_fire = out_valid & out_ready;

    // A batch end abandons the transaction, so no event is reported for it
    assign commit = (state == OUTPUT) && out_fire && !batch_completed;
    assign reject = (state == CHECK) && conflict && !batch_completed;
    assign done   = (state == COMPLETE) && !batch_completed;

    // Control FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            out_valid <= 1'b0;
        end else if (batch_completed) begin
            state     <= IDLE;
            out_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (in_fire) begin
                        state <= CHECK;
                    end
                end
                CHECK: begin
                    // Flags are valid for the whole check cycle
                    if (conflict) begin
                        state <= COMPLETE;
                    end else begin
                        state     <= OUTPUT;
                        out_valid <= 1'b1;
                    end
                end
                OUTPUT: begin
                    // Wait here as long as the sink applies back-pressure
                    if (out_ready) begin
                        state     <= COMPLETE;
                        out_valid <= 1'b0;
                    end
                end
                COMPLETE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Payload capture on acceptance, output load after a clean check
    always_ff @(posedge clk) begin
        if (in_fire) begin
            held_owner_id   <= in_owner_id;
            held_read_deps  <= in_read_deps;
            held_write_deps <= in_write_deps;
        end
        if (state == CHECK && !conflict) begin
            out_owner_id   <= held_owner_id;
            out_read_deps  <= held_read_deps;
            out_write_deps <= held_write_deps;
        end
    end

    // Output stays put until the sink takes it
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !batch_completed |=>
            out_valid && $stable(out_owner_id) &&
            $stable(out_read_deps) && $stable(out_write_deps)
    );

    // A transaction is either merged into the batch or dropped, never both
    a_commit_xor_reject: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(commit && reject)
    );

endmodule

// ==== verilog/dep_conflict_check.sv ====
`timescale 1ns/1ps

module dep_conflict_check import txn_pkg::*; (
    input  logic [DEP_W-1:0] read_deps,
    input  logic [DEP_W-1:0] write_deps,
    input  logic [DEP_W-1:0] batch_reads,
    input  logic [DEP_W-1:0] batch_writes,
    output logic             raw,
    output logic             waw,
    output logic             war
);

    // One conflict bit per slice and kind
    logic [NUM_CHUNKS-1:0] raw_chunk;
    logic [NUM_CHUNKS-1:0] waw_chunk;
    logic [NUM_CHUNKS-1:0] war_chunk;

    for (genvar c = 0; c < NUM_CHUNKS; c++) begin : g_chunk
        localparam int LO = c * CHUNK_W;
        // Last slice is clipped to the vector width
        localparam int HI = ((c + 1) * CHUNK_W - 1 < DEP_W - 1) ?
                            ((c + 1) * CHUNK_W - 1) : (DEP_W - 1);

        // New read against earlier writes
        assign raw_chunk[c] = |(read_deps[HI:LO] & batch_writes[HI:LO]);

        // New write against earlier writes
        assign waw_chunk[c] = |(write_deps[HI:LO] & batch_writes[HI:LO]);

        // New write against earlier reads
        assign war_chunk[c] = |(write_deps[HI:LO] & batch_reads[HI:LO]);
    end

    // Merge the slices
    assign raw = |raw_chunk;
    assign waw = |waw_chunk;
    assign war = |war_chunk;

endmodule

// ==== verilog/perf_counters.sv ====
`timescale 1ns/1ps

module perf_counters import perf_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             batch_completed,
    input  logic             reject,
    input  logic             done,
    input  logic             raw,
    input  logic             waw,
    input  logic             war,
    output logic [CNT_W-1:0] raw_conflicts,
    output logic [CNT_W-1:0] waw_conflicts,
    output logic [CNT_W-1:0] war_conflicts,
    output logic [CNT_W-1:0] filter_hits,
    output logic [CNT_W-1:0] transactions_processed
);

    // Conflict statistics accumulate across batches
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raw_conflicts <= '0;
            waw_conflicts <= '0;
            war_conflicts <= '0;
            filter_hits   <= '0;
        end else if (reject) begin
            filter_hits <= filter_hits + 1'b1;
            // One drop may count under several kinds
            if (raw) begin
                raw_conflicts <= raw_conflicts + 1'b1;
            end
            if (waw) begin
                waw_conflicts <= waw_conflicts + 1'b1;
            end
            if (war) begin
                war_conflicts <= war_conflicts + 1'b1;
            end
        end
    end

    // Per-batch count of finished transactions, forwarded or dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            transactions_processed <= '0;
        end else if (batch_completed) begin
            transactions_processed <= '0;
        end else if (done) begin
            transactions_processed <= transactions_processed + 1'b1;
        end
    end

endmodule

// ==== verilog/perf_pkg.sv ====
package perf_pkg;

    // Width of every performance counter
    localparam int CNT_W = 32;

endpackage

// ==== verilog/txn_pkg.sv ====
package txn_pkg;

    // Dependency vectors carry one bit per tracked account or resource
    localparam int DEP_W = 256;

    // Owner program id of each transaction
    localparam int ID_W = 64;

    // Width of one slice checked in parallel
    localparam int CHUNK_W = 64;

    // Slice count, rounded up so a partial last slice is still covered
    localparam int NUM_CHUNKS = (DEP_W + CHUNK_W - 1) / CHUNK_W;

endpackage
